// File: bench/fetchStage1Tb.sv
// fetch stage 1 testbench with clock, reset, memory model, stimulus, assertions and watchdog
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetchStage1Tb
    import predPkg::*;
    import fetchPkg::*;
();

    localparam int period      = 4;
    localparam int resetCycles = 4;
    localparam int randCycles  = 40;
    localparam int dirCycles   = 40;
    localparam int slackCycles = 20;

    // addresses used by the directed tests
    localparam logic [31:0] bootPc  = 32'h0000_1000;
    localparam logic [31:0] jumpPc  = 32'h0000_2000;
    localparam logic [31:0] jumpTgt = 32'h0000_3000;
    localparam logic [31:0] brPc    = 32'h0000_4000;
    localparam logic [31:0] brTgt   = 32'h0000_4800;
    localparam logic [31:0] callPc  = 32'h0000_5004;
    localparam logic [31:0] funcPc  = 32'h0000_6000;
    localparam logic [31:0] retPc   = 32'h0000_6010;

    logic                   clk;
    logic                   reset;
    logic [`PC_WIDTH-1:0]   startPc_i;
    logic                   stall_i;
    logic                   fetchReq_o;
    logic [`PC_WIDTH-1:0]   instPC_o    [0:`FETCH_WIDTH-1];
    logic [`INST_WIDTH-1:0] inst_i      [0:`FETCH_WIDTH-1];
    logic                   instValid_i;
    predUpdate_t            predUpdate_i;
    logic                   recoverFlag_i;
    logic [`PC_WIDTH-1:0]   recoverPc_i;
    logic                   fs2RecoverFlag_i;
    logic [`PC_WIDTH-1:0]   fs2RecoverPc_i;
    logic                   fs2MissedCall_i;
    logic [`PC_WIDTH-1:0]   fs2CallPc_i;
    logic                   fs2MissedReturn_i;
    fs2Pkt_t                fs2Packet_o [0:`FETCH_WIDTH-1];
    logic                   fs1Ready_o;
    logic [`PC_WIDTH-1:0]   addrRas_o;

    // expected values armed one cycle before they are sampled
    logic [31:0] expPc;
    logic        checkPc;
    logic        expHit;
    brType_t     expType;
    logic        checkHit;
    logic [31:0] expTgt;
    logic        checkTgt;
    logic [1:0]  expCnt;
    logic        checkCnt;
    logic [31:0] expRas;
    logic        checkRas;

    // pc the dut should show in the cycle being driven
    logic [31:0] curPc;
    int          valueErrors;
    int          otherErrors;

    fetchStage1 dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // word pattern over the whole address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic predUpdate_t makeUpdate(input logic [31:0] pc, input logic [31:0] npc,
                                               input brType_t t, input logic d,
                                               input logic [1:0] c);
        predUpdate_t u;
        u.valid   = 1'b1;
        u.pc      = pc;
        u.npc     = npc;
        u.brType  = t;
        u.dir     = d;
        u.counter = c;
        return u;
    endfunction

    // memory answers in the same cycle
    always_comb
    begin
        for (int l = 0; l < `FETCH_WIDTH; l++)
            inst_i[l] = memWord(instPC_o[l]);
    end

    // start a cycle with quiet inputs and the pc check armed
    task automatic tick();
        @(posedge clk);
        instValid_i        <= 1'b1;
        stall_i            <= 1'b0;
        recoverFlag_i      <= 1'b0;
        fs2RecoverFlag_i   <= 1'b0;
        fs2MissedCall_i    <= 1'b0;
        fs2MissedReturn_i  <= 1'b0;
        predUpdate_i.valid <= 1'b0;
        expPc              <= curPc;
        checkPc            <= 1'b1;
        checkHit           <= 1'b0;
        checkTgt           <= 1'b0;
        checkCnt           <= 1'b0;
        checkRas           <= 1'b0;
    endtask

    // plain bundle with no btb entry for these lanes
    task automatic advance();
        tick();
        curPc = curPc + 8;
    endtask

    task automatic redirect(input logic [31:0] addr);
        tick();
        recoverFlag_i <= 1'b1;
        recoverPc_i   <= addr;
        curPc = addr;
    endtask

    // update strobe with fetch idle so pc holds
    task automatic sendUpdate(input logic [31:0] pc, input logic [31:0] npc,
                              input brType_t t, input logic d, input logic [1:0] c);
        tick();
        instValid_i  <= 1'b0;
        predUpdate_i <= makeUpdate(pc, npc, t, d, c);
    endtask

    // train the branch counter, then fetch it once
    task automatic condRound(input logic d, input logic [1:0] oldCnt,
                             input logic [1:0] newCnt);
        sendUpdate(brPc, brTgt, brCondBranch, d, oldCnt);
        redirect(brPc);
        tick();
        checkHit <= 1'b1;
        expHit   <= 1'b1;
        expType  <= brCondBranch;
        checkCnt <= 1'b1;
        expCnt   <= newCnt;
        // counter 2 or 3 means taken
        curPc = newCnt[1] ? brTgt : brPc + 8;
    endtask

    reqLowInReset: assert property (@(posedge clk) reset |-> !fetchReq_o)
        else
        begin
            otherErrors++;
            $display("fetch request was high while reset was asserted at %0t", $time);
        end

    pcMatch: assert property (@(posedge clk) disable iff (reset) checkPc |-> instPC_o[0] == expPc)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: instPC_o[0] = %h, expected %h",
                     $time, $sampled(instPC_o[0]), $sampled(expPc));
        end

    lanePcStep: assert property (@(posedge clk) disable iff (reset)
                                 checkPc |-> instPC_o[1] == expPc + `INST_BYTES)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: instPC_o[1] = %h, expected %h", $time,
                     $sampled(instPC_o[1]), $sampled(expPc) + `INST_BYTES);
        end

    // request stays up after reset so a lane is valid with instValid_i
    readyRule: assert property (@(posedge clk) disable iff (reset)
                                fs1Ready_o == instValid_i)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs1Ready_o = %b, expected %b", $time,
                     $sampled(fs1Ready_o), $sampled(instValid_i));
        end

    // per-lane packet pc, valid bit and instruction word
    for (genvar l = 0; l < `FETCH_WIDTH; l++)
    begin : gPktCheck
        pktPcMatch: assert property (@(posedge clk) disable iff (reset)
                                     checkPc |-> fs2Packet_o[l].pc == expPc + l * `INST_BYTES)
            else
            begin
                valueErrors++;
                $display("Fail at %0t: fs2Packet_o[%0d].pc = %h, expected %h", $time, l,
                         $sampled(fs2Packet_o[l].pc), $sampled(expPc) + l * `INST_BYTES);
            end

        pktValidMatch: assert property (@(posedge clk) disable iff (reset)
                                        fs2Packet_o[l].valid == instValid_i)
            else
            begin
                valueErrors++;
                $display("Fail at %0t: fs2Packet_o[%0d].valid = %b, expected %b", $time, l,
                         $sampled(fs2Packet_o[l].valid), $sampled(instValid_i));
            end

        // valid lane carries the memory word and an idle lane zero
        pktInstMatch: assert property (@(posedge clk) disable iff (reset)
                                       fs2Packet_o[l].inst ==
                                       (instValid_i ? memWord(instPC_o[l]) : 32'h0))
            else
            begin
                valueErrors++;
                $display("Fail at %0t: fs2Packet_o[%0d].inst = %h, expected %h", $time, l,
                         $sampled(fs2Packet_o[l].inst),
                         $sampled(instValid_i) ? memWord($sampled(instPC_o[l])) : 32'h0);
            end
    end

    hitMatch: assert property (@(posedge clk) disable iff (reset)
                               checkHit |-> fs2Packet_o[0].btbHit == expHit)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs2Packet_o[0].btbHit = %b, expected %b",
                     $time, $sampled(fs2Packet_o[0].btbHit), $sampled(expHit));
        end

    typeMatch: assert property (@(posedge clk) disable iff (reset)
                                checkHit |-> fs2Packet_o[0].ctrlType == expType)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs2Packet_o[0].ctrlType = %0d, expected %0d",
                     $time, $sampled(fs2Packet_o[0].ctrlType), $sampled(expType));
        end

    targetMatch: assert property (@(posedge clk) disable iff (reset)
                                  checkTgt |-> fs2Packet_o[0].takenPc == expTgt)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs2Packet_o[0].takenPc = %h, expected %h",
                     $time, $sampled(fs2Packet_o[0].takenPc), $sampled(expTgt));
        end

    counterMatch: assert property (@(posedge clk) disable iff (reset)
                                   checkCnt |-> fs2Packet_o[0].predCounter == expCnt)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs2Packet_o[0].predCounter = %0d, expected %0d",
                     $time, $sampled(fs2Packet_o[0].predCounter), $sampled(expCnt));
        end

    // direction is the counter msb
    dirMatch: assert property (@(posedge clk) disable iff (reset)
                               checkCnt |-> fs2Packet_o[0].predDir == expCnt[1])
        else
        begin
            valueErrors++;
            $display("Fail at %0t: fs2Packet_o[0].predDir = %b, expected %b",
                     $time, $sampled(fs2Packet_o[0].predDir), $sampled(expCnt[1]));
        end

    rasMatch: assert property (@(posedge clk) disable iff (reset) checkRas |-> addrRas_o == expRas)
        else
        begin
            valueErrors++;
            $display("Fail at %0t: addrRas_o = %h, expected %h",
                     $time, $sampled(addrRas_o), $sampled(expRas));
        end

    initial
    begin
        logic [31:0] rng;
        rng               = 32'ha3e9_d441;
        reset             = 1'b1;
        startPc_i         = bootPc;
        stall_i           = 1'b0;
        instValid_i       = 1'b0;
        predUpdate_i      = '0;
        recoverFlag_i     = 1'b0;
        recoverPc_i       = '0;
        fs2RecoverFlag_i  = 1'b0;
        fs2RecoverPc_i    = '0;
        fs2MissedCall_i   = 1'b0;
        fs2CallPc_i       = '0;
        fs2MissedReturn_i = 1'b0;
        {checkPc, checkHit, checkTgt, checkCnt, checkRas} = '0;
        {expPc, expHit, expTgt, expCnt, expRas} = '0;
        expType           = brJump;
        valueErrors       = 0;
        otherErrors       = 0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        wait (fetchReq_o === 1'b1);
        curPc = bootPc;

        // random drops and stalls with an empty btb
        for (int n = 0; n < randCycles; n++)
        begin
            rng = xorshift(rng);
            tick();
            instValid_i <= (rng[2:0] != 3'd0);
            stall_i     <= (rng[9:7] == 3'd0);
            if (rng[2:0] != 3'd0 && rng[9:7] != 3'd0)
                curPc = curPc + 8;
        end

        // taken jump
        sendUpdate(jumpPc, jumpTgt, brJump, 1'b1, 2'd0);
        redirect(jumpPc);
        tick();
        checkHit <= 1'b1;
        expHit   <= 1'b1;
        expType  <= brJump;
        checkTgt <= 1'b1;
        expTgt   <= jumpTgt;
        curPc = jumpTgt;
        advance();

        // counter steps 1 to 2, 2 to 1, 2 to 3 and 1 to 0
        condRound(1'b1, 2'd1, 2'd2);
        condRound(1'b0, 2'd2, 2'd1);
        condRound(1'b1, 2'd2, 2'd3);
        condRound(1'b0, 2'd1, 2'd0);

        // call in lane 1 and return at function end
        sendUpdate(callPc, funcPc, brCall, 1'b1, 2'd0);
        sendUpdate(retPc, 32'h0, brReturn, 1'b1, 2'd0);
        redirect(callPc - 4);
        tick();
        curPc = funcPc;
        advance();
        checkRas <= 1'b1;
        expRas   <= callPc + 4;
        advance();
        tick();
        checkHit <= 1'b1;
        expHit   <= 1'b1;
        expType  <= brReturn;
        checkTgt <= 1'b1;
        expTgt   <= callPc + 4;
        curPc = callPc + 4;
        advance();
        // stack back to its reset entry
        checkRas <= 1'b1;
        expRas   <= 32'h0;

        // backend recovery wins over fs2 and stall
        tick();
        recoverFlag_i    <= 1'b1;
        recoverPc_i      <= 32'h0000_7000;
        fs2RecoverFlag_i <= 1'b1;
        fs2RecoverPc_i   <= 32'h0000_7800;
        stall_i          <= 1'b1;
        curPc = 32'h0000_7000;
        // fs2 redirect wins over stall
        tick();
        fs2RecoverFlag_i <= 1'b1;
        fs2RecoverPc_i   <= 32'h0000_7800;
        stall_i          <= 1'b1;
        curPc = 32'h0000_7800;
        tick();
        stall_i <= 1'b1;
        // fs2 missed call pushes its pc
        tick();
        fs2RecoverFlag_i <= 1'b1;
        fs2MissedCall_i  <= 1'b1;
        fs2CallPc_i      <= 32'h0000_7a00;
        fs2RecoverPc_i   <= 32'h0000_7a04;
        curPc = 32'h0000_7a04;
        advance();
        checkRas <= 1'b1;
        expRas   <= 32'h0000_7a00;
        // missed return goes to the stack top instead of fs2RecoverPc_i
        tick();
        fs2RecoverFlag_i  <= 1'b1;
        fs2MissedReturn_i <= 1'b1;
        fs2RecoverPc_i    <= 32'h0000_7c00;
        curPc = 32'h0000_7a00;
        advance();
        checkRas <= 1'b1;
        expRas   <= 32'h0;

        // drain the last armed checks
        tick();
        instValid_i <= 1'b0;
        @(posedge clk);
        {checkPc, checkHit, checkTgt, checkCnt, checkRas} <= '0;
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // bound on the whole run
    initial
    begin
        #((resetCycles + randCycles + dirCycles + slackCycles) * period);
        $display("watchdog expired before the stimulus completed");
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/predPkg.sv
verilog/fetchPkg.sv
verilog/branchTargetBuffer.sv
verilog/bimodalPredictor.sv
verilog/returnAddrStack.sv
verilog/nextPcControl.sv
verilog/fetchStage1.sv
bench/fetchStage1Tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch stage 1 testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fetchStage1Tb \
    -f filelist.f -o fetchSim
./obj_dir/fetchSim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Simulation finished: PASS" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi

// File: verilog/bimodalPredictor.sv
// bimodal table of two-bit counters with per-lane lookup and saturating update
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module bimodalPredictor
    import predPkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [`PC_WIDTH-1:0]     pc_i,
    input  wire predUpdate_t              update_i,
    output logic [`FETCH_WIDTH-1:0]       predDir_o,
    output logic [1:0]                    predCounter_o [0:`FETCH_WIDTH-1]
);

    localparam int offsetBits = $clog2(`INST_BYTES);
    localparam int entries    = 1 << `BP_INDEX_BITS;

    logic [1:0]                counter [0:entries-1];
    logic                      wrEn;
    logic [`BP_INDEX_BITS-1:0] wrIndex;
    logic [1:0]                stepped;

    // only conditional branches train the table
    assign wrEn    = update_i.valid & (update_i.brType == brCondBranch);
    assign wrIndex = update_i.pc[offsetBits +: `BP_INDEX_BITS];

    // move retired counter one step toward outcome
    // saturates at 0 and 3
    always_comb
    begin
        if (update_i.dir)
            stepped = (update_i.counter == 2'b11) ? 2'b11 : update_i.counter + 2'b01;
        else
            stepped = (update_i.counter == 2'b00) ? 2'b00 : update_i.counter - 2'b01;
    end

    // reset to weakly not-taken
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < entries; i++)
                counter[i] <= 2'b01;
        end
        else if (wrEn)
            counter[wrIndex] <= stepped;
    end

    // lookup per lane, msb gives direction
    for (genvar lane = 0; lane < `FETCH_WIDTH; lane++)
    begin : gLane
        logic [`PC_WIDTH-1:0] lanePc;

        assign lanePc              = pc_i + lane * `INST_BYTES;
        assign predCounter_o[lane] = counter[lanePc[offsetBits +: `BP_INDEX_BITS]];
        assign predDir_o[lane]     = predCounter_o[lane][1];
    end

endmodule

`default_nettype wire

// File: verilog/branchTargetBuffer.sv
// direct-mapped tagged branch target table, one lookup per lane, one write port
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module branchTargetBuffer
    import predPkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic [`PC_WIDTH-1:0] pc_i,
    input  wire predUpdate_t  update_i,
    output btbLookup_t        lookup_o [0:`FETCH_WIDTH-1]
);

    localparam int offsetBits = $clog2(`INST_BYTES);
    localparam int tagBits    = `PC_WIDTH - `BTB_INDEX_BITS - offsetBits;
    localparam int entries    = 1 << `BTB_INDEX_BITS;

    // entry fields, only valid bits are reset
    logic [entries-1:0]        entryValid;
    logic [tagBits-1:0]        entryTag    [0:entries-1];
    brType_t                   entryType   [0:entries-1];
    logic [`PC_WIDTH-1:0]      entryTarget [0:entries-1];

    logic                      wrEn;
    logic [`BTB_INDEX_BITS-1:0] wrIndex;
    logic [tagBits-1:0]        wrTag;

    // only taken control transfers get an entry
    assign wrEn    = update_i.valid & update_i.dir;
    assign wrIndex = update_i.pc[offsetBits +: `BTB_INDEX_BITS];
    assign wrTag   = update_i.pc[`PC_WIDTH-1 -: tagBits];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            entryValid <= '0;
        else if (wrEn)
            entryValid[wrIndex] <= 1'b1;
    end

    // tag, type and target written with the valid bit
    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            entryTag[wrIndex]    <= wrTag;
            entryType[wrIndex]   <= update_i.brType;
            entryTarget[wrIndex] <= update_i.npc;
        end
    end

    // per-lane read, each lane uses its own pc
    for (genvar lane = 0; lane < `FETCH_WIDTH; lane++)
    begin : gLane
        logic [`PC_WIDTH-1:0]       lanePc;
        logic [`BTB_INDEX_BITS-1:0] rdIndex;
        logic [tagBits-1:0]         rdTag;

        assign lanePc  = pc_i + lane * `INST_BYTES;
        assign rdIndex = lanePc[offsetBits +: `BTB_INDEX_BITS];
        assign rdTag   = lanePc[`PC_WIDTH-1 -: tagBits];

        // hit needs a live entry with matching tag
        assign lookup_o[lane].hit      = entryValid[rdIndex] & (entryTag[rdIndex] == rdTag);
        assign lookup_o[lane].ctrlType = entryType[rdIndex];
        assign lookup_o[lane].takenPc  = entryTarget[rdIndex];
    end

endmodule

`default_nettype wire

// File: verilog/fetchPkg.sv
// second-stage fetch packet and return-stack command types
`default_nettype none

`include "fetch_defs.svh"

package fetchPkg;

    import predPkg::*;

    // one lane handed to fetch stage 2
    typedef struct packed {
        logic [`PC_WIDTH-1:0]   pc;
        logic [`INST_WIDTH-1:0] inst;
        logic                   valid;
        logic                   btbHit;
        brType_t                ctrlType;
        logic [`PC_WIDTH-1:0]   takenPc;
        logic                   predDir;
        logic [1:0]             predCounter;
    } fs2Pkt_t;

    // push and pop request to the ras
    typedef struct packed {
        logic                 push;
        logic                 pop;
        logic [`PC_WIDTH-1:0] pushAddr;
    } rasCmd_t;

endpackage

`default_nettype wire

// File: verilog/fetchStage1.sv
// fetch stage 1 top, next-pc control with btb, bimodal predictor and ras
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetchStage1
    import predPkg::*;
    import fetchPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`PC_WIDTH-1:0]   startPc_i,
    input  wire logic                   stall_i,
    // raw memory port, answered in the same cycle
    output logic                        fetchReq_o,
    output logic [`PC_WIDTH-1:0]        instPC_o    [0:`FETCH_WIDTH-1],
    input  wire logic [`INST_WIDTH-1:0] inst_i      [0:`FETCH_WIDTH-1],
    input  wire logic                   instValid_i,
    // retire-order update strobe
    input  wire predUpdate_t            predUpdate_i,
    // backend and fs2 redirects
    input  wire logic                   recoverFlag_i,
    input  wire logic [`PC_WIDTH-1:0]   recoverPc_i,
    input  wire logic                   fs2RecoverFlag_i,
    input  wire logic [`PC_WIDTH-1:0]   fs2RecoverPc_i,
    input  wire logic                   fs2MissedCall_i,
    input  wire logic [`PC_WIDTH-1:0]   fs2CallPc_i,
    input  wire logic                   fs2MissedReturn_i,
    output fs2Pkt_t                     fs2Packet_o [0:`FETCH_WIDTH-1],
    output logic                        fs1Ready_o,
    output logic [`PC_WIDTH-1:0]        addrRas_o
);

    logic [`PC_WIDTH-1:0]    pc;
    btbLookup_t              btbLookup   [0:`FETCH_WIDTH-1];
    logic [`FETCH_WIDTH-1:0] predDir;
    logic [1:0]              predCounter [0:`FETCH_WIDTH-1];
    rasCmd_t                 rasCmd;

    nextPcControl control0 (
        .clk               (clk),
        .reset             (reset),
        .startPc_i         (startPc_i),
        .stall_i           (stall_i),
        .recoverFlag_i     (recoverFlag_i),
        .recoverPc_i       (recoverPc_i),
        .fs2RecoverFlag_i  (fs2RecoverFlag_i),
        .fs2RecoverPc_i    (fs2RecoverPc_i),
        .fs2MissedCall_i   (fs2MissedCall_i),
        .fs2CallPc_i       (fs2CallPc_i),
        .fs2MissedReturn_i (fs2MissedReturn_i),
        .instValid_i       (instValid_i),
        .inst_i            (inst_i),
        .btbLookup_i       (btbLookup),
        .predDir_i         (predDir),
        .predCounter_i     (predCounter),
        .rasTop_i          (addrRas_o),
        .pc_o              (pc),
        .fetchReq_o        (fetchReq_o),
        .instPC_o          (instPC_o),
        .rasCmd_o          (rasCmd),
        .fs2Packet_o       (fs2Packet_o),
        .fs1Ready_o        (fs1Ready_o)
    );

    // btb writes only on taken updates
    branchTargetBuffer btb0 (
        .clk      (clk),
        .reset    (reset),
        .pc_i     (pc),
        .update_i (predUpdate_i),
        .lookup_o (btbLookup)
    );

    // counters train on conditional branches only
    bimodalPredictor bp0 (
        .clk           (clk),
        .reset         (reset),
        .pc_i          (pc),
        .update_i      (predUpdate_i),
        .predDir_o     (predDir),
        .predCounter_o (predCounter)
    );

    // stack top also goes out for fs2 missed returns
    returnAddrStack ras0 (
        .clk      (clk),
        .reset    (reset),
        .cmd_i    (rasCmd),
        .rasTop_o (addrRas_o)
    );

endmodule

`default_nettype wire

// File: verilog/fetch_defs.svh
// lane count, pc and instruction widths, predictor table sizes
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// lanes fetched per cycle
`define FETCH_WIDTH     2

// address and instruction widths
`define PC_WIDTH        32
`define INST_WIDTH      32
`define INST_BYTES      4

// 16-entry direct-mapped btb
`define BTB_INDEX_BITS  4

// 64 two-bit counters
`define BP_INDEX_BITS   6

// 8-deep return stack
`define RAS_DEPTH_LOG   3

`endif

// File: verilog/nextPcControl.sv
// pc register, fetch request, taken-lane select, next-pc mux, ras command, fs2 packets
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module nextPcControl
    import predPkg::*;
    import fetchPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`PC_WIDTH-1:0]   startPc_i,
    input  wire logic                   stall_i,
    input  wire logic                   recoverFlag_i,
    input  wire logic [`PC_WIDTH-1:0]   recoverPc_i,
    input  wire logic                   fs2RecoverFlag_i,
    input  wire logic [`PC_WIDTH-1:0]   fs2RecoverPc_i,
    input  wire logic                   fs2MissedCall_i,
    input  wire logic [`PC_WIDTH-1:0]   fs2CallPc_i,
    input  wire logic                   fs2MissedReturn_i,
    input  wire logic                   instValid_i,
    input  wire logic [`INST_WIDTH-1:0] inst_i        [0:`FETCH_WIDTH-1],
    input  wire btbLookup_t             btbLookup_i   [0:`FETCH_WIDTH-1],
    input  wire logic [`FETCH_WIDTH-1:0] predDir_i,
    input  wire logic [1:0]             predCounter_i [0:`FETCH_WIDTH-1],
    input  wire logic [`PC_WIDTH-1:0]   rasTop_i,
    output logic [`PC_WIDTH-1:0]        pc_o,
    output logic                        fetchReq_o,
    output logic [`PC_WIDTH-1:0]        instPC_o      [0:`FETCH_WIDTH-1],
    output rasCmd_t                     rasCmd_o,
    output fs2Pkt_t                     fs2Packet_o   [0:`FETCH_WIDTH-1],
    output logic                        fs1Ready_o
);

    localparam int offsetBits = $clog2(`INST_BYTES);
    localparam int laneBits   = (`FETCH_WIDTH > 1) ? $clog2(`FETCH_WIDTH) : 1;

    logic [`FETCH_WIDTH-1:0] laneValid;
    logic [`FETCH_WIDTH-1:0] takenVect;
    logic [laneBits-1:0]     firstLane;
    logic                    anyTaken;
    logic [laneBits:0]       numValid;
    btbLookup_t              takenEntry;
    logic [`PC_WIDTH-1:0]    predNpc;
    logic [`PC_WIDTH-1:0]    predPushAddr;
    logic                    predPush;
    logic                    predPop;
    logic [`PC_WIDTH-1:0]    nextPc;

    // one valid bit covers the whole bundle
    assign laneValid  = {`FETCH_WIDTH{fetchReq_o & instValid_i}};
    assign fs1Ready_o = laneValid[0];

    // lane pcs and taken vector
    // taken = valid, btb hit, and predicted taken or unconditional
    for (genvar lane = 0; lane < `FETCH_WIDTH; lane++)
    begin : gLane
        assign instPC_o[lane]  = pc_o + lane * `INST_BYTES;
        assign takenVect[lane] = laneValid[lane] & btbLookup_i[lane].hit
                               & (predDir_i[lane]
                               | (btbLookup_i[lane].ctrlType != brCondBranch));
    end

    // lowest taken lane wins, scan from the top down
    always_comb
    begin
        anyTaken  = 1'b0;
        firstLane = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--)
        begin
            if (takenVect[i])
            begin
                anyTaken  = 1'b1;
                firstLane = i[laneBits-1:0];
            end
        end
    end

    // valid lanes for sequential advance
    always_comb
    begin
        numValid = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++)
            numValid = numValid + laneValid[i];
    end

    // predicted target of the bundle
    assign takenEntry   = btbLookup_i[firstLane];
    assign predPushAddr = instPC_o[firstLane] + `INST_BYTES;
    assign predPush     = anyTaken & (takenEntry.ctrlType == brCall);
    assign predPop      = anyTaken & (takenEntry.ctrlType == brReturn);

    always_comb
    begin
        if (!anyTaken)
            predNpc = pc_o + `INST_BYTES * numValid;
        else if (takenEntry.ctrlType == brReturn)
            predNpc = rasTop_i;
        else
            predNpc = takenEntry.takenPc;
    end

    // redirects first, stall holds, else prediction
    always_comb
    begin
        if (recoverFlag_i)
            nextPc = recoverPc_i;
        else if (fs2RecoverFlag_i)
            nextPc = fs2MissedReturn_i ? rasTop_i : fs2RecoverPc_i;
        else if (stall_i)
            nextPc = pc_o;
        else
            nextPc = predNpc;
    end

    // ras command
    // fs2 fixups beat predicted ops; backend recovery or stall drops predicted ops
    always_comb
    begin
        rasCmd_o.push     = 1'b0;
        rasCmd_o.pop      = 1'b0;
        rasCmd_o.pushAddr = predPushAddr;
        if (recoverFlag_i)
        begin
            rasCmd_o.push = 1'b0;
        end
        else if (fs2RecoverFlag_i)
        begin
            if (fs2MissedCall_i)
            begin
                rasCmd_o.push     = 1'b1;
                rasCmd_o.pushAddr = fs2CallPc_i;
            end
            else if (fs2MissedReturn_i)
                rasCmd_o.pop = 1'b1;
        end
        else if (!stall_i)
        begin
            rasCmd_o.push = predPush;
            rasCmd_o.pop  = predPop;
        end
    end

    // pc register, loads start address in reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pc_o <= startPc_i;
        else
            pc_o <= nextPc;
    end

    // request rises on first edge out of reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            fetchReq_o <= 1'b0;
        else
            fetchReq_o <= 1'b1;
    end

    // per-lane packets to fetch stage 2
    always_comb
    begin
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            fs2Packet_o[i].pc          = instPC_o[i];
            fs2Packet_o[i].inst        = laneValid[i] ? inst_i[i] : '0;
            fs2Packet_o[i].valid       = laneValid[i];
            fs2Packet_o[i].btbHit      = btbLookup_i[i].hit;
            fs2Packet_o[i].ctrlType    = btbLookup_i[i].ctrlType;
            // returns carry the stack top as target
            fs2Packet_o[i].takenPc     = (btbLookup_i[i].ctrlType == brReturn)
                                       ? rasTop_i : btbLookup_i[i].takenPc;
            fs2Packet_o[i].predDir     = predDir_i[i];
            fs2Packet_o[i].predCounter = predCounter_i[i];
        end
    end

    // targets from btb, ras and redirects must keep word alignment
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pc_o[offsetBits-1:0] == '0
    );

endmodule

`default_nettype wire

// File: verilog/predPkg.sv
// branch-type enum, predictor update struct and btb lookup struct
`default_nettype none

`include "fetch_defs.svh"

package predPkg;

    // control-transfer class
    // both bits set marks a conditional branch
    typedef enum logic [1:0] {
        brJump       = 2'b00,
        brCall       = 2'b01,
        brReturn     = 2'b10,
        brCondBranch = 2'b11
    } brType_t;

    // retire-order update from the branch queue
    typedef struct packed {
        logic                 valid;
        logic [`PC_WIDTH-1:0] pc;
        logic [`PC_WIDTH-1:0] npc;
        brType_t              brType;
        logic                 dir;
        logic [1:0]           counter;
    } predUpdate_t;

    // per-lane btb answer
    typedef struct packed {
        logic                 hit;
        brType_t              ctrlType;
        logic [`PC_WIDTH-1:0] takenPc;
    } btbLookup_t;

endpackage

`default_nettype wire

// File: verilog/returnAddrStack.sv
// circular return address stack with push, pop and top-of-stack read
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module returnAddrStack
    import fetchPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire rasCmd_t              cmd_i,
    output logic [`PC_WIDTH-1:0]      rasTop_o
);

    localparam int depth = 1 << `RAS_DEPTH_LOG;

    logic [`PC_WIDTH-1:0]     stack [0:depth-1];
    logic [`RAS_DEPTH_LOG-1:0] tos;
    logic [`RAS_DEPTH_LOG-1:0] tosUp;
    logic [`RAS_DEPTH_LOG-1:0] tosDown;

    // pointer wraps, oldest entry gets overwritten on overflow
    assign tosUp   = tos + 1'b1;
    assign tosDown = tos - 1'b1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tos <= '0;
            for (int i = 0; i < depth; i++)
                stack[i] <= '0;
        end
        else if (cmd_i.push)
        begin
            // write above top, then move top up
            stack[tosUp] <= cmd_i.pushAddr;
            tos          <= tosUp;
        end
        else if (cmd_i.pop)
        begin
            // entry stays, only the pointer drops
            tos <= tosDown;
        end
    end

    // current top drives redirect and packet target
    assign rasTop_o = stack[tos];

    // control side must never ask for both in one cycle
    pushPopExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(cmd_i.push && cmd_i.pop)
    );

endmodule

`default_nettype wire
